//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= muldiv_unit_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+hdl
hdl/muldiv_pkg.sv
hdl/operand_issue.sv
hdl/muldiv_step.sv
hdl/result_collect.sv
hdl/muldiv_unit.sv
verif/muldiv_unit_tb.sv

//--- hdl/muldiv_defs.svh
`ifndef MULDIV_DEFS_SVH
`define MULDIV_DEFS_SVH

// datapath width of the processor
`define MD_WIDTH 16

// one bit-step per stage
// must stay equal to MD_WIDTH
`define MD_STAGES 16

// source registers the operands are picked from
`define MD_NSRC 4

`endif

//--- hdl/muldiv_pkg.sv
`default_nettype none

`include "muldiv_defs.svh"

package muldiv_pkg;

	// encoding matches the processor's operation field
	typedef enum logic [1:0] {
		op_shl = 2'd0,
		op_mul = 2'd1,
		op_div = 2'd2,
		op_shr = 2'd3
	} md_op_e;

	typedef logic [`MD_WIDTH-1:0] md_word_t;

	// one word of the pipeline, one per stage register
	typedef struct packed {
		logic valid;
		md_op_e op;
		// negate the final result
		logic neg;
		// divisor was zero
		logic dbz;
		// multiplicand, or dividend shifting out
		md_word_t a;
		// multiplier, or divisor
		md_word_t b;
		// product accumulator, or quotient
		md_word_t acc;
		// partial remainder, one bit wider than the data
		logic [`MD_WIDTH:0] rem;
	} md_stage_t;

	// output register of the unit
	typedef struct packed {
		logic done;
		logic dbz;
		md_word_t value;
	} md_result_t;

endpackage

`default_nettype wire

//--- hdl/muldiv_step.sv
`default_nettype none

`include "muldiv_defs.svh"

module muldiv_step #(
	parameter int STEP = 0
) (
	input  logic                  clk,
	input  logic                  rst,
	input  muldiv_pkg::md_stage_t stage_in,
	output muldiv_pkg::md_stage_t stage_out
);
	import muldiv_pkg::*;

	localparam int W = `MD_WIDTH;
	// dividend bit handled here, msb first
	localparam int DBIT = W - 1 - STEP;

	md_word_t addend;
	logic [W:0] trial;
	logic [W:0] divisor;
	logic fits;
	md_stage_t stage_d;
	md_stage_t payload_q;
	logic valid_q;

	// partial product of this bit
	assign addend = stage_in.a << STEP;

	// remainder is below the divisor, so its top bit is free
	assign trial = {stage_in.rem[W-1:0], stage_in.a[DBIT]};
	assign divisor = {1'b0, stage_in.b};
	assign fits = (trial >= divisor);

	always_comb begin
		stage_d = stage_in;
		case (stage_in.op)
			op_mul: begin
				if (stage_in.b[STEP]) begin
					stage_d.acc = stage_in.acc + addend;
				end
			end
			op_div: begin
				// restoring step
				stage_d.rem = trial;
				if (fits) begin
					stage_d.rem = trial - divisor;
					stage_d.acc[DBIT] = 1'b1;
				end
			end
			default: begin
				// shift result already sits in acc
				stage_d = stage_in;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= stage_in.valid;
		end
	end

	always_ff @(posedge clk) begin
		payload_q <= stage_d;
	end

	always_comb begin
		stage_out = payload_q;
		stage_out.valid = valid_q;
	end

	// holds only if every earlier step and the issue kept rem below b
	a_rem_bound: assert property (@(posedge clk) disable iff (rst)
		(stage_in.valid && stage_in.op == op_div && !stage_in.dbz)
			|-> ({1'b0, stage_in.rem} < {stage_in.b, 1'b0}));

endmodule

`default_nettype wire

//--- hdl/muldiv_unit.sv
`default_nettype none

`include "muldiv_defs.svh"

module muldiv_unit (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   start,
	input  muldiv_pkg::md_op_e                     op,
	input  logic                                   signed_mode,
	input  logic [1:0]                             src1_sel,
	input  logic [1:0]                             src2_sel,
	input  muldiv_pkg::md_word_t [`MD_NSRC-1:0]    src_regs,
	output muldiv_pkg::md_word_t                   result,
	output logic                                   done,
	output logic                                   div_by_zero
);
	import muldiv_pkg::*;

	// stage_in[k] feeds step k, the last one feeds the collector
	md_stage_t stage_in [0:`MD_STAGES];

	operand_issue i_operand_issue (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.op          (op),
		.signed_mode (signed_mode),
		.src1_sel    (src1_sel),
		.src2_sel    (src2_sel),
		.src_regs    (src_regs),
		.stage_out   (stage_in[0])
	);

	for (genvar k = 0; k < `MD_STAGES; k++) begin : g_step
		muldiv_step #(
			.STEP (k)
		) i_muldiv_step (
			.clk       (clk),
			.rst       (rst),
			.stage_in  (stage_in[k]),
			.stage_out (stage_in[k+1])
		);
	end

	result_collect i_result_collect (
		.clk         (clk),
		.rst         (rst),
		.stage_in    (stage_in[`MD_STAGES]),
		.result      (result),
		.done        (done),
		.div_by_zero (div_by_zero)
	);

endmodule

`default_nettype wire

//--- hdl/operand_issue.sv
`default_nettype none

`include "muldiv_defs.svh"

module operand_issue (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   start,
	input  muldiv_pkg::md_op_e                     op,
	input  logic                                   signed_mode,
	input  logic [1:0]                             src1_sel,
	input  logic [1:0]                             src2_sel,
	input  muldiv_pkg::md_word_t [`MD_NSRC-1:0]    src_regs,
	output muldiv_pkg::md_stage_t                  stage_out
);
	import muldiv_pkg::*;

	localparam int W = `MD_WIDTH;

	md_word_t opnd1;
	md_word_t opnd2;
	md_word_t mag1;
	md_word_t mag2;
	logic [3:0] shamt;
	md_stage_t stage_d;
	md_stage_t payload_q;
	logic valid_q;

	// two's complement magnitude, 0x8000 stays 0x8000 and reads as unsigned
	function automatic md_word_t magnitude(input md_word_t v, input logic use_sign);
		if (use_sign && v[W-1]) begin
			return -v;
		end
		return v;
	endfunction

	assign opnd1 = src_regs[src1_sel];
	assign opnd2 = src_regs[src2_sel];

	assign mag1 = magnitude(opnd1, signed_mode);
	assign mag2 = magnitude(opnd2, signed_mode);

	// shift by 1 to 8 places
	assign shamt = {1'b0, opnd2[2:0]} + 4'd1;

	always_comb begin
		stage_d = '0;
		stage_d.valid = start;
		stage_d.op = op;
		case (op)
			op_shl: begin
				stage_d.a = opnd1;
				stage_d.acc = opnd1 << shamt;
			end
			op_shr: begin
				stage_d.a = opnd1;
				stage_d.acc = opnd1 >> shamt;
			end
			default: begin
				// multiply and divide run on magnitudes
				stage_d.a = mag1;
				stage_d.b = mag2;
				stage_d.neg = signed_mode & (opnd1[W-1] ^ opnd2[W-1]);
				stage_d.dbz = (op == op_div) && (opnd2 == '0);
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= stage_d.valid;
		end
	end

	// payload follows the inputs every cycle, only valid qualifies it
	always_ff @(posedge clk) begin
		payload_q <= stage_d;
	end

	always_comb begin
		stage_out = payload_q;
		stage_out.valid = valid_q;
	end

	a_op_known: assert property (@(posedge clk) disable iff (rst)
		start |-> !$isunknown(op));

endmodule

`default_nettype wire

//--- hdl/result_collect.sv
`default_nettype none

module result_collect (
	input  logic                  clk,
	input  logic                  rst,
	input  muldiv_pkg::md_stage_t stage_in,
	output muldiv_pkg::md_word_t  result,
	output logic                  done,
	output logic                  div_by_zero
);
	import muldiv_pkg::*;

	md_word_t value_d;
	md_result_t res_q;

	// divide by zero wins over the sign
	always_comb begin
		if (stage_in.dbz) begin
			value_d = '1;
		end else if (stage_in.neg) begin
			value_d = -stage_in.acc;
		end else begin
			value_d = stage_in.acc;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			res_q <= '0;
		end else begin
			res_q.done <= stage_in.valid;
			res_q.dbz <= stage_in.valid & stage_in.dbz;
			// value holds until the next result
			if (stage_in.valid) begin
				res_q.value <= value_d;
			end
		end
	end

	assign result = res_q.value;
	assign done = res_q.done;
	assign div_by_zero = res_q.dbz;

	// only a divide can carry a zero divisor
	a_dbz_only_div: assert property (@(posedge clk) disable iff (rst)
		(stage_in.valid && stage_in.dbz) |-> (stage_in.op == op_div));

endmodule

`default_nettype wire

//--- verif/muldiv_unit_tb.sv
`default_nettype none

`include "muldiv_defs.svh"

module muldiv_unit_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import muldiv_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	// issue register plus one per step plus the collector
	localparam int LATENCY = `MD_STAGES + 1;
	localparam int N_SHIFT = `MD_NSRC * 8 * 2 * 2;
	localparam int N_MUL = 15;
	localparam int N_DIV = 16;
	localparam int N_RAND = 40;
	localparam int N_OPS = N_SHIFT + N_MUL + N_DIV + N_RAND;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_OPS + LATENCY + 50;
	localparam logic [31:0] SEED = 32'he8d835e1;

	typedef struct packed {
		md_word_t value;
		logic dbz;
		logic [31:0] launch;
	} expect_t;

	logic clk;
	logic rst;
	logic start;
	md_op_e op;
	logic signed_mode;
	logic [1:0] src1_sel;
	logic [1:0] src2_sel;
	md_word_t [`MD_NSRC-1:0] src_regs;
	md_word_t result;
	logic done;
	logic div_by_zero;

	expect_t exp_q[$];
	int unsigned cycle = 0;
	int errors;
	int checks;
	logic checking;
	logic [31:0] lcg_state;
	logic [1:0] sel_rot;
	md_word_t last_result;

	muldiv_unit i_muldiv_unit (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.op          (op),
		.signed_mode (signed_mode),
		.src1_sel    (src1_sel),
		.src2_sel    (src2_sel),
		.src_regs    (src_regs),
		.result      (result),
		.done        (done),
		.div_by_zero (div_by_zero)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	function automatic md_word_t rand_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	// reference model in plain integer arithmetic
	function automatic expect_t expected_result(input md_op_e f_op, input logic sgn,
			input md_word_t x, input md_word_t y);
		longint sx;
		longint sy;
		int amt;
		expect_t e;
		e = '0;
		amt = int'(y[2:0]) + 1;
		if (sgn) begin
			sx = longint'($signed(x));
			sy = longint'($signed(y));
		end else begin
			sx = longint'(x);
			sy = longint'(y);
		end
		case (f_op)
			op_shl: e.value = x << amt;
			op_shr: e.value = x >> amt;
			op_mul: e.value = md_word_t'(sx * sy);
			default: begin
				if (y == '0) begin
					e.value = 16'hffff;
					e.dbz = 1'b1;
				end else begin
					// truncates toward zero
					e.value = md_word_t'(sx / sy);
				end
			end
		endcase
		return e;
	endfunction

	task automatic compare_value(input string name, input md_word_t got,
			input md_word_t expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("Error: %s got %h expected %h", name, got, expected);
		end
	endtask

	task automatic report_and_finish();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	endtask

	// one operation per falling edge
	// start stays high until idle drops it
	task automatic launch(input md_op_e l_op, input logic sgn, input logic [1:0] s1,
			input logic [1:0] s2, input md_word_t x, input md_word_t y);
		expect_t e;
		@(negedge clk);
		for (int i = 0; i < `MD_NSRC; i++) begin
			src_regs[i] = rand_word();
		end
		src_regs[s1] = x;
		src_regs[s2] = y;
		start = 1'b1;
		op = l_op;
		signed_mode = sgn;
		src1_sel = s1;
		src2_sel = s2;
		e = expected_result(l_op, sgn, src_regs[s1], src_regs[s2]);
		// start is sampled by the next rising edge
		e.launch = cycle + 1;
		exp_q.push_back(e);
	endtask

	task automatic launch_rotating(input md_op_e l_op, input logic sgn,
			input md_word_t x, input md_word_t y);
		launch(l_op, sgn, sel_rot, sel_rot + 2'd1, x, y);
		sel_rot = sel_rot + 2'd1;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			start = 1'b0;
		end
	endtask

	task automatic check_done();
		expect_t e;
		if (done) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("done pulse at cycle %0d with no operation in flight", cycle);
			end else begin
				e = exp_q.pop_front();
				compare_value("result", result, e.value);
				compare_value("div_by_zero", md_word_t'(div_by_zero), md_word_t'(e.dbz));
				checks++;
				assert (cycle == e.launch + LATENCY) else begin
					errors++;
					$display("done came %0d cycles after start instead of %0d",
						cycle - e.launch, LATENCY);
				end
			end
			last_result = result;
		end else begin
			// result holds between pulses
			compare_value("result", result, last_result);
			compare_value("div_by_zero", md_word_t'(div_by_zero), '0);
		end
	endtask

	always @(negedge clk) begin
		if (checking) begin
			check_done();
		end
	end

	task automatic test_reset();
		@(negedge clk);
		compare_value("done", md_word_t'(done), '0);
		compare_value("div_by_zero", md_word_t'(div_by_zero), '0);
		compare_value("result", result, '0);
		last_result = result;
		checking <= 1'b1;
	endtask

	task automatic test_shifts();
		md_word_t y;
		for (int s1 = 0; s1 < `MD_NSRC; s1++) begin
			for (int amt = 1; amt <= 8; amt++) begin
				for (int m = 0; m < 2; m++) begin
					y = rand_word();
					y[2:0] = 3'(amt - 1);
					launch(op_shl, m[0], 2'(s1), 2'(`MD_NSRC - 1 - s1), rand_word(), y);
					launch(op_shr, m[0], 2'(s1), 2'(`MD_NSRC - 1 - s1), rand_word(), y);
				end
			end
		end
	endtask

	task automatic test_multiply();
		launch_rotating(op_mul, 1'b0, 16'h0003, 16'h0005);
		launch_rotating(op_mul, 1'b0, 16'hffff, 16'hffff);
		launch_rotating(op_mul, 1'b0, 16'h1234, 16'h5678);
		launch_rotating(op_mul, 1'b0, 16'h0000, 16'habcd);
		launch_rotating(op_mul, 1'b0, 16'h00ff, 16'h0101);
		launch_rotating(op_mul, 1'b1, 16'hfffd, 16'h0005);
		launch_rotating(op_mul, 1'b1, 16'hfff9, 16'hfff7);
		launch_rotating(op_mul, 1'b1, 16'h8000, 16'hffff);
		launch_rotating(op_mul, 1'b1, 16'h7fff, 16'h0002);
		launch_rotating(op_mul, 1'b1, 16'h4000, 16'hfffc);
		launch_rotating(op_mul, 1'b1, 16'h04d2, 16'hffff);
		for (int i = 0; i < 4; i++) begin
			launch_rotating(op_mul, i[0], rand_word(), rand_word());
		end
	endtask

	task automatic test_divide();
		launch_rotating(op_div, 1'b0, 16'h0064, 16'h0007);
		launch_rotating(op_div, 1'b0, 16'hffff, 16'h0001);
		launch_rotating(op_div, 1'b0, 16'h0005, 16'h0009);
		launch_rotating(op_div, 1'b0, 16'habcd, 16'h0000);
		launch_rotating(op_div, 1'b0, 16'hffff, 16'h00ff);
		idle(2);
		launch_rotating(op_div, 1'b1, 16'h8000, 16'hffff);
		launch_rotating(op_div, 1'b1, 16'hfff9, 16'h0002);
		launch_rotating(op_div, 1'b1, 16'h0007, 16'hfffe);
		launch_rotating(op_div, 1'b1, 16'hfff9, 16'hfffe);
		launch_rotating(op_div, 1'b1, 16'h8000, 16'h0001);
		launch_rotating(op_div, 1'b1, 16'h0000, 16'h0000);
		launch_rotating(op_div, 1'b1, 16'h7fff, 16'h8000);
		idle(3);
		for (int i = 0; i < 4; i++) begin
			launch_rotating(op_div, i[0], rand_word(), rand_word());
		end
	endtask

	task automatic test_back_to_back();
		md_word_t r;
		for (int i = 0; i < N_RAND; i++) begin
			r = rand_word();
			launch(md_op_e'(r[1:0]), r[2], r[4:3], r[6:5], rand_word(), rand_word());
		end
	endtask

	initial begin
		rst = 1'b1;
		start = 1'b0;
		op = op_shl;
		signed_mode = 1'b0;
		src1_sel = 2'd0;
		src2_sel = 2'd0;
		src_regs = '0;
		errors = 0;
		checks = 0;
		checking = 1'b0;
		lcg_state = SEED;
		sel_rot = 2'd0;
		last_result = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_reset();
		test_shifts();
		test_multiply();
		test_divide();
		test_back_to_back();
		idle(1);

		// let the pipeline drain, then watch the hold a few cycles
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		idle(3);
		report_and_finish();
	end

	initial begin
		while (cycle < TIMEOUT_CYCLES) begin
			@(posedge clk);
		end
		errors++;
		$display("timeout after %0d cycles with %0d operations still in flight",
			cycle, exp_q.size());
		report_and_finish();
	end

endmodule

`default_nettype wire
